// ==== hw/cpuPkg.sv ====
package cpuPkg;

    // Datapath width
    localparam int xlen = 32;

    // Instruction memory, word addressed
    localparam int imemDepth = 256;
    localparam int imemAddrW = 8;

    // Data memory, word addressed
    localparam int dmemDepth = 256;
    localparam int dmemAddrW = 8;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011
    } opcodeT;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,  // Signed compare
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluPassB = 4'd8   // Operand b straight through
    } aluOpT;

    // Immediate formats
    typedef enum logic [1:0] {
        immI = 2'd0,
        immS = 2'd1,
        immB = 2'd2,
        immU = 2'd3
    } immSelT;

endpackage

// ==== hw/instMem.sv ====
`timescale 1ns/10ps

module instMem (
    input  logic                         CLK,
    input  logic                         progWe,
    input  logic [cpuPkg::imemAddrW-1:0] progAddr,
    input  logic [cpuPkg::xlen-1:0]      progData,
    input  logic [cpuPkg::imemAddrW-1:0] rdAddr,
    output logic [cpuPkg::xlen-1:0]      instr
);
    import cpuPkg::*;

    logic [xlen-1:0] mem [imemDepth];

    // Loader port only, the core never writes here
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Fetch is combinational from the PC word index
    assign instr = mem[rdAddr];

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic [cpuPkg::xlen-1:0] wd,
    input  logic                    we,
    output logic [cpuPkg::xlen-1:0] rd1,
    output logic [cpuPkg::xlen-1:0] rd2
);
    import cpuPkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin  // x0 never written
            regs[rd] <= wd;
        end
    end

    // Two combinational read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 reads as zero on both ports at every retire edge
    a_x0ReadsZero : assert property (
        @(posedge CLK) disable iff (!rstN)
        ((rs1 == 5'd0) |-> (rd1 == '0)) and ((rs2 == 5'd0) |-> (rd2 == '0))
    ) else $error("x0 read returned a non-zero value");

endmodule

// ==== hw/immGen.sv ====
`timescale 1ns/10ps

module immGen (
    input  logic [cpuPkg::xlen-1:0] instr,
    input  cpuPkg::immSelT          immSel,
    output logic [cpuPkg::xlen-1:0] imm
);
    import cpuPkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instr[6:0]);

    always_comb begin
        case (immSel)
            immI: imm = {{(xlen-12){instr[31]}}, instr[31:20]};
            immS: imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
            // Offset is in bytes, bit 0 implied zero
            immB: imm = {{(xlen-13){instr[31]}}, instr[31], instr[7],
                         instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    // Branch targets must come from the B format
    always_comb begin
        if (opcode == opBranch) begin
            a_branchImm : assert final (immSel == immB)
                else $error("branch immediate not taken from the B format");
        end
    end

endmodule

// ==== hw/decoder.sv ====
`timescale 1ns/10ps

module decoder (
    input  logic [cpuPkg::xlen-1:0] instr,
    output logic                    regWe,
    output logic                    aluSrc,
    output logic                    memWe,
    output logic                    memToReg,
    output logic                    branch,
    output logic                    branchNe,
    output logic                    luiSel,
    output cpuPkg::aluOpT           aluOp,
    output cpuPkg::immSelT          immSel
);
    import cpuPkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    aluOpT      funcOp;   // ALU op implied by funct3
    logic       rLegal;
    logic       iLegal;

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Bit 30 only on sub and no sltu
    assign rLegal = ((funct7 == 7'b0000000) && (funct3 != 3'b011))
                 || ((funct7 == 7'b0100000) && (funct3 == 3'b000));
    assign iLegal = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

    // ALU control
    always_comb begin
        case (funct3)
            3'b000:  funcOp = ((opcode == opReg) && instr[30]) ? aluSub : aluAdd;
            3'b001:  funcOp = aluSll;
            3'b010:  funcOp = aluSlt;
            3'b100:  funcOp = aluXor;
            3'b101:  funcOp = aluSrl;
            3'b110:  funcOp = aluOr;
            3'b111:  funcOp = aluAnd;
            default: funcOp = aluAdd;
        endcase
    end

    // Main control
    always_comb begin
        regWe    = 1'b0;
        aluSrc   = 1'b0;
        memWe    = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        luiSel   = 1'b0;
        aluOp    = aluAdd;
        immSel   = immI;
        case (opcode)
            opReg: begin
                regWe = rLegal;
                aluOp = funcOp;
            end
            opImm: begin
                regWe  = iLegal;
                aluSrc = 1'b1;
                aluOp  = funcOp;
            end
            opLoad: begin
                regWe    = (funct3 == 3'b010);  // lw only
                memToReg = (funct3 == 3'b010);
                aluSrc   = 1'b1;
            end
            opStore: begin
                memWe  = (funct3 == 3'b010);    // sw only
                aluSrc = 1'b1;
                immSel = immS;
            end
            opBranch: begin
                branch   = (funct3 == 3'b000) || (funct3 == 3'b001);
                branchNe = funct3[0];
                aluOp    = aluSub;               // Equality through the zero flag
                immSel   = immB;
            end
            opLui: begin
                regWe  = 1'b1;
                luiSel = 1'b1;
                aluSrc = 1'b1;
                aluOp  = aluPassB;
                immSel = immU;
            end
            default: ;                           // Illegal, no side effects
        endcase
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [cpuPkg::xlen-1:0] a,
    input  logic [cpuPkg::xlen-1:0] b,
    input  cpuPkg::aluOpT           aluOp,
    output logic [cpuPkg::xlen-1:0] result,
    output logic                    zero
);
    import cpuPkg::*;

    logic       lessThan;
    logic [4:0] shamt;

    assign lessThan = $signed(a) < $signed(b);
    assign shamt    = b[4:0];  // Upper bits of b ignored for shifts

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {{(xlen-1){1'b0}}, lessThan};
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;  // Logical
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    // Used by beq and bne after a subtract
    assign zero = (result == '0);

endmodule

// ==== hw/dataMem.sv ====
`timescale 1ns/10ps

module dataMem (
    input  logic                         CLK,
    input  logic [cpuPkg::dmemAddrW-1:0] addr,
    input  logic                         we,
    input  logic [cpuPkg::xlen-1:0]      wd,
    output logic [cpuPkg::xlen-1:0]      rd
);
    import cpuPkg::*;

    logic [xlen-1:0] mem [dmemDepth];

    // Store lands on the retire edge
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rd = mem[addr];  // Load data ready in the same cycle

endmodule

// ==== hw/singleCpu.sv ====
`timescale 1ns/10ps

module singleCpu (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [cpuPkg::imemAddrW-1:0] progAddr,
    input  logic [cpuPkg::xlen-1:0]      progData,
    output logic [cpuPkg::xlen-1:0]      pc,
    output logic [cpuPkg::xlen-1:0]      OUT,
    output logic                         trRegWe,
    output logic [4:0]                   trRegAddr,
    output logic [cpuPkg::xlen-1:0]      trRegData,
    output logic                         trMemWe,
    output logic [cpuPkg::xlen-1:0]      trMemAddr,
    output logic [cpuPkg::xlen-1:0]      trMemData
);
    import cpuPkg::*;

    logic [xlen-1:0] instr;
    logic            regWe;
    logic            aluSrc;
    logic            memWe;
    logic            memToReg;
    logic            branch;
    logic            branchNe;
    logic            luiSel;
    aluOpT           aluOp;
    immSelT          immSel;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] result;
    logic            zero;
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] wbData;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic            takeBranch;
    logic [xlen-1:0] nextPc;

    // Program counter, held at 0 through reset
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm;                // imm already doubled
    assign takeBranch   = branch && (zero != branchNe);
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    instMem u_instMem (
        .CLK      (CLK),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .rdAddr   (pc[imemAddrW+1:2]),
        .instr    (instr)
    );

    decoder u_decoder (
        .instr    (instr),
        .regWe    (regWe),
        .aluSrc   (aluSrc),
        .memWe    (memWe),
        .memToReg (memToReg),
        .branch   (branch),
        .branchNe (branchNe),
        .luiSel   (luiSel),
        .aluOp    (aluOp),
        .immSel   (immSel)
    );

    immGen u_immGen (
        .instr  (instr),
        .immSel (immSel),
        .imm    (imm)
    );

    regFile u_regFile (
        .CLK  (CLK),
        .rstN (rstN),
        .rs1  (instr[19:15]),
        .rs2  (instr[24:20]),
        .rd   (instr[11:7]),
        .wd   (wbData),
        .we   (regWe),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    assign aluB = aluSrc ? imm : rd2;

    alu u_alu (
        .a      (rd1),
        .b      (aluB),
        .aluOp  (aluOp),
        .result (result),
        .zero   (zero)
    );

    // Stores blocked while the loader owns the core
    dataMem u_dataMem (
        .CLK  (CLK),
        .addr (result[dmemAddrW+1:2]),
        .we   (memWe && rstN),
        .wd   (rd2),
        .rd   (rdata)
    );

    always_comb begin
        if (memToReg) begin
            wbData = rdata;
        end else if (luiSel) begin
            wbData = imm;
        end else begin
            wbData = result;
        end
    end

    // Commit trace for the instruction retiring at the next edge
    assign OUT       = instr;
    assign trRegWe   = regWe && (instr[11:7] != 5'd0);  // Writes to x0 are dropped
    assign trRegAddr = instr[11:7];
    assign trRegData = wbData;
    assign trMemWe   = memWe;
    assign trMemAddr = result;
    assign trMemData = rd2;

    a_wordAligned : assert property (
        @(posedge CLK) disable iff (!rstN)
        (memWe || memToReg) |-> (result[1:0] == 2'b00)
    ) else $error("misaligned data access at 0x%08h", result);

    // Loading a program is only allowed with the core in reset
    a_progInReset : assert property (
        @(posedge CLK) progWe |-> !rstN
    ) else $error("program write while core running");

endmodule

// ==== tb/tbSingleCpu.sv ====
`timescale 1ns/10ps

module tbSingleCpu;
    import cpuPkg::*;

    localparam int clkPeriod     = 100;
    localparam int numTests      = 5;
    localparam int cyclesPerTest = 300;
    localparam int progLen       = 60;  // Self-loop in the last slot
    localparam int resetCycles   = 10;

    logic                 CLK;
    logic                 rstN;
    logic                 progWe;
    logic [imemAddrW-1:0] progAddr;
    logic [xlen-1:0]      progData;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      OUT;
    logic                 trRegWe;
    logic [4:0]           trRegAddr;
    logic [xlen-1:0]      trRegData;
    logic                 trMemWe;
    logic [xlen-1:0]      trMemAddr;
    logic [xlen-1:0]      trMemData;

    logic [31:0] prog [progLen];
    logic [31:0] rngState;
    logic [31:0] mPc;           // Reference model state
    logic [31:0] mRegs [32];
    logic [31:0] mMem [256];
    int          testErrors;
    int          passCount;
    int          failCount;

    singleCpu u_dut (
        .CLK       (CLK),
        .rstN      (rstN),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .pc        (pc),
        .OUT       (OUT),
        .trRegWe   (trRegWe),
        .trRegAddr (trRegAddr),
        .trRegData (trRegData),
        .trMemWe   (trMemWe),
        .trMemAddr (trMemAddr),
        .trMemData (trMemData)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Instruction encoders, one per RV32I format
    function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sWord(input logic [11:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bWord(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // Integer ops as the ISA defines them
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subtract,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return subtract ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic genProgram();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        int          off;
        int          maxSkip;
        // x7 is the only base register, set to 512 then stored to 496..524
        prog[0] = iWord(12'd512, 5'd0, 3'b000, 5'd7, 7'b0010011);
        for (int k = 0; k < 8; k++) begin
            prog[1 + k] = sWord(12'(4 * k - 16), 5'(k), 5'd7);  // Also shows reset regs
        end
        for (int i = 9; i < progLen - 1; i++) begin
            r   = nextRand();
            rd  = r[7:4] % 4'd7;  // x0..x6
            rs1 = {2'b00, r[10:8]};
            rs2 = {2'b00, r[13:11]};
            f3  = r[18:16];
            off = 4 * int'(r[17:16]) - 8;
            if (r[3:0] < 4'd5) begin
                if (f3 == 3'b011) begin
                    prog[i] = rWord(7'b0100000, rs2, rs1, 3'b000, rd);  // sub
                end else begin
                    prog[i] = rWord(7'b0000000, rs2, rs1, f3, rd);
                end
            end else if (r[3:0] < 4'd8) begin
                if (f3 != 3'b111) begin
                    f3[0] = 1'b0;
                end
                prog[i] = iWord(r[31:20], rs1, f3, rd, 7'b0010011);
            end else if (r[3:0] == 4'd8) begin
                prog[i] = {r[31:12], rd, 7'b0110111};
            end else if (r[3:0] == 4'd9) begin
                prog[i] = iWord(12'(504 + 8 * (r[17:16] % 3)), 5'd0, 3'b000, 5'd7, 7'b0010011);
            end else if (r[3:0] < 4'd12) begin
                prog[i] = sWord(12'(off), rs2, 5'd7);
            end else if (r[3:0] < 4'd14) begin
                prog[i] = iWord(12'(off), 5'd7, 3'b010, rd, 7'b0000011);
            end else begin
                maxSkip = (progLen - 1 - i < 4) ? progLen - 1 - i : 4;
                off     = 4 * (1 + int'(r[17:16]) % maxSkip);  // Never past the loop
                prog[i] = bWord(13'(off), r[19] ? rs1 : rs2, rs1, {2'b00, r[20]});
            end
        end
        prog[progLen - 1] = bWord(13'd0, 5'd0, 5'd0, 3'b000);  // beq x0, x0, 0
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h at %0t",
                     name, expected, actual, $time);
            testErrors++;
        end
    endtask

    // Predict the retiring instruction, compare the trace, then update the model
    task automatic checkRetire(output logic [31:0] nextPc);
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] eRegData;
        logic [31:0] eMemAddr;
        logic        eRegWe;
        logic        eMemWe;
        instr    = prog[mPc[31:2]];
        a        = mRegs[instr[19:15]];
        b        = mRegs[instr[24:20]];
        immI     = {{20{instr[31]}}, instr[31:20]};
        eRegWe   = 1'b0;
        eMemWe   = 1'b0;
        eRegData = '0;
        eMemAddr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        nextPc   = mPc + 32'd4;
        case (instr[6:0])
            7'b0110011: {eRegWe, eRegData} = {1'b1, aluRef(instr[14:12], instr[30], a, b)};
            7'b0010011: {eRegWe, eRegData} = {1'b1, aluRef(instr[14:12], 1'b0, a, immI)};
            7'b0000011: {eRegWe, eRegData} = {1'b1, mMem[(a + immI) >> 2]};
            7'b0110111: {eRegWe, eRegData} = {1'b1, instr[31:12], 12'h000};
            7'b0100011: eMemWe = 1'b1;
            7'b1100011: begin
                if ((a == b) != instr[12]) begin
                    nextPc = mPc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                    instr[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        eRegWe = eRegWe && (instr[11:7] != 5'd0);  // x0 stays zero
        checkValue("pc", mPc, pc);
        checkValue("OUT", instr, OUT);
        checkValue("trRegWe", 32'(eRegWe), 32'(trRegWe));
        checkValue("trMemWe", 32'(eMemWe), 32'(trMemWe));
        if (eRegWe) begin
            checkValue("trRegAddr", 32'(instr[11:7]), 32'(trRegAddr));
            checkValue("trRegData", eRegData, trRegData);
            mRegs[instr[11:7]] = eRegData;
        end
        if (eMemWe) begin
            checkValue("trMemAddr", eMemAddr, trMemAddr);
            checkValue("trMemData", b, trMemData);
            mMem[eMemAddr[9:2]] = b;
        end
    endtask

    task automatic runTest(input int t);
        logic [31:0] nextPc;
        logic        done;
        int          retired;
        genProgram();
        @(posedge CLK);
        rstN <= 1'b0;
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            progWe   <= 1'b1;
            progAddr <= imemAddrW'(i);
            progData <= prog[i];
        end
        @(posedge CLK);
        progWe <= 1'b0;
        repeat (resetCycles) @(posedge CLK);  // Quiet reset after the load
        rstN <= 1'b1;
        mPc = 32'h0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = 32'h0;
        end
        testErrors = 0;
        retired    = 0;
        done       = 1'b0;
        @(negedge CLK);
        checkValue("pc after reset", 32'h0, pc);
        while (!done) begin
            checkRetire(nextPc);
            done = (nextPc == mPc);  // Self-loop reached
            mPc  = nextPc;
            retired++;
            @(negedge CLK);
        end
        if (testErrors == 0) begin
            $display("Test %0d ok, %0d instructions retired", t, retired);
            passCount++;
        end else begin
            $display("Test %0d FAILED with %0d mismatches", t, testErrors);
            failCount++;
        end
    endtask

    initial begin
        CLK       = 1'b0;
        rstN      = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        rngState  = 32'd11;
        passCount = 0;
        failCount = 0;
        for (int t = 1; t <= numTests; t++) begin
            runTest(t);
        end
        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(numTests * cyclesPerTest * clkPeriod);
        $display("Timeout: the run did not finish within %0d cycles",
                 numTests * cyclesPerTest);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== list.f ====
hw/cpuPkg.sv
hw/instMem.sv
hw/regFile.sv
hw/immGen.sv
hw/decoder.sv
hw/alu.sv
hw/dataMem.sv
hw/singleCpu.sv
tb/tbSingleCpu.sv
